// ==== tb.f ====
common/rv_isa_pkg.sv
common/ex_ctrl_pkg.sv
src/ex_decode.sv
alu/ex_alu.sv
lsu/lsu_store.sv
src/ex_result_reg.sv
src/ex_stage.sv
tests/ex_stage_assert.sv
tests/tb_ex_stage.sv

// ==== Makefile ====
# Verilator flow for the execute stage testbench
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up as a line of its own
run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_ex_stage.sv ====
`default_nettype none

module tb_ex_stage import rv_isa_pkg::*, ex_ctrl_pkg::*; ();

  localparam int NUM_INST    = 3000; // random cycles after reset, idle ones included
  localparam int RST_TIMEOUT = 20;   // cycles allowed for reset to clear

  // expected outputs of one cycle, as the model predicts them
  typedef struct packed {
    logic              valid;
    logic [4:0]        rd;
    logic [XLEN-1:0]   rd_wdata;
    logic [XLEN-1:0]   next_pc;
    logic [XLEN-1:0]   addr;
    logic [MASK_W-1:0] mask;
    logic [XLEN-1:0]   st_wdata;
    logic              wen;
    logic              trap;
    logic              halt;
    logic              chk_wd; // rd data only matters for a real register write
    logic              chk_st; // store fields are compared for every store opcode
  } exp_t;

  logic              i_clk, i_rst, i_valid;
  logic [XLEN-1:0]   i_inst, i_pc, i_rs1_rdata, i_rs2_rdata;
  logic              o_valid, o_dmem_wen, o_trap, o_halt;
  logic [4:0]        o_rd_waddr;
  logic [XLEN-1:0]   o_rd_wdata, o_next_pc, o_dmem_addr, o_dmem_wdata;
  logic [MASK_W-1:0] o_dmem_mask;

  integer seed;
  int     word_errs, rd_errs, mask_errs, flag_errs, other_errs;
  exp_t   exp_q[$]; // one entry per driven cycle, popped one cycle later
  logic   rst_ok;

  ex_stage UUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // all inputs start quiet, reset is released on a falling edge after three cycles
  initial begin
    i_rst       = 1'b1;
    i_valid     = 1'b0;
    i_inst      = '0;
    i_pc        = '0;
    i_rs1_rdata = '0;
    i_rs2_rdata = '0;
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
  end

  task automatic check_word(input string name, input logic [XLEN-1:0] got, exp);
    if (got !== exp) begin
      word_errs++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr5(input string name, input logic [4:0] got, exp);
    if (got !== exp) begin
      rd_errs++;
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_mask(input string name, input logic [MASK_W-1:0] got, exp);
    if (got !== exp) begin
      mask_errs++;
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) begin
      flag_errs++;
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  // integer operation by funct3, alt selects sub or the arithmetic shift
  function automatic logic [XLEN-1:0] ref_alu(input logic [2:0] f3, input logic alt,
                                              input logic [XLEN-1:0] x, y);
    case (f3)
      F3_ADD_SUB: ref_alu = alt ? x - y : x + y;
      F3_SLL:     ref_alu = x << y[4:0];
      F3_SLT:     ref_alu = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      F3_SLTU:    ref_alu = (x < y) ? 32'd1 : 32'd0;
      F3_XOR:     ref_alu = x ^ y;
      F3_SRL_SRA: ref_alu = alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
      F3_OR:      ref_alu = x | y;
      default:    ref_alu = x & y;
    endcase
  endfunction

  function automatic logic branch_holds(input logic [2:0] f3, input logic [XLEN-1:0] x, y);
    case (f3)
      F3_BEQ:  branch_holds = (x == y);
      F3_BNE:  branch_holds = (x != y);
      F3_BLT:  branch_holds = ($signed(x) < $signed(y));
      F3_BGE:  branch_holds = !($signed(x) < $signed(y));
      F3_BLTU: branch_holds = (x < y);
      F3_BGEU: branch_holds = !(x < y);
      default: branch_holds = 1'b0; // codes 010 and 011 do not exist
    endcase
  endfunction

  function automatic exp_t predict(input inst_u in, input logic [XLEN-1:0] pc, a, b);
    exp_t            e;
    logic [XLEN-1:0] w, imm_i, imm_s, imm_b, imm_j, ea, tgt;
    logic            wr, tk, ill, mis;
    w     = in;
    imm_i = {{20{w[31]}}, in.i.imm};
    imm_s = {{20{w[31]}}, in.s.imm_hi, in.s.imm_lo};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0}; // raw bit order of the B format
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    e         = '0;
    e.valid   = 1'b1;
    e.next_pc = pc + 4;
    {wr, tk, ill, mis} = '0;
    tgt = '0;
    ea  = a + imm_s; // byte address a store would touch
    case (in.r.opcode)
      OPC_OP: begin
        wr         = 1'b1;
        e.rd_wdata = ref_alu(in.r.funct3, in.r.funct7[5], a, b);
      end
      OPC_OP_IMM: begin
        wr         = 1'b1; // only srai reads bit 30 of the immediate
        e.rd_wdata = ref_alu(in.i.funct3, (in.i.funct3 == F3_SRL_SRA) && w[30], a, imm_i);
      end
      OPC_LUI: begin
        wr         = 1'b1;
        e.rd_wdata = {w[31:12], 12'h000};
      end
      OPC_AUIPC: begin
        wr         = 1'b1;
        e.rd_wdata = pc + {w[31:12], 12'h000};
      end
      OPC_JAL, OPC_JALR: begin
        wr         = 1'b1;
        tk         = 1'b1;
        e.rd_wdata = pc + 4; // link address
        tgt = (in.r.opcode == OPC_JAL) ? pc + imm_j : (a + imm_i) & ~32'd1;
      end
      OPC_BRANCH: begin
        ill = (in.s.funct3 == 3'b010) || (in.s.funct3 == 3'b011);
        tk  = branch_holds(in.s.funct3, a, b);
        tgt = pc + imm_b;
      end
      OPC_STORE: begin
        e.chk_st   = 1'b1;
        e.addr     = {ea[XLEN-1:2], 2'b00};
        e.st_wdata = b; // an unknown size passes the data through unshifted
        case (in.s.funct3)
          F3_SB: begin
            e.mask     = 4'b0001 << ea[1:0];
            e.st_wdata = {24'd0, b[7:0]} << (8 * ea[1:0]);
          end
          F3_SH: begin
            e.mask     = ea[1] ? 4'b1100 : 4'b0011;
            e.st_wdata = {16'd0, b[15:0]} << (16 * ea[1]);
            mis        = ea[0];
          end
          F3_SW: begin
            e.mask = 4'b1111;
            mis    = |ea[1:0];
          end
          default: ill = 1'b1;
        endcase
      end
      OPC_SYSTEM: e.halt = (w == INST_EBREAK); // any other system word does nothing
      default:    ill = 1'b1;
    endcase
    e.trap = ill || (e.chk_st && mis) || (tk && tgt[1:0] != 2'b00);
    if (tk) e.next_pc = tgt;
    e.chk_wd = wr && !e.trap;
    e.rd     = e.chk_wd ? in.r.rd : 5'd0;
    e.wen    = e.chk_st && !e.trap;
    return e;
  endfunction

  function automatic logic known_opcode(input logic [6:0] op);
    return op inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                      OPC_BRANCH, OPC_STORE, OPC_SYSTEM};
  endfunction

  // one random cycle on the falling edge, kind 15 leaves the stage idle
  task automatic drive_random();
    logic [3:0]      kind;
    logic [XLEN-1:0] w;
    inst_u           in;
    exp_t            e;
    kind = 4'($random(seed));
    w    = $random(seed);
    in   = w;
    case (kind)
      4'd0, 4'd1, 4'd2: begin
        in.r.opcode = OPC_OP;
        in.r.funct7 = {1'b0, w[30], 5'b00000};
      end
      4'd3, 4'd4:  in.r.opcode = OPC_OP_IMM;
      4'd5:        in.r.opcode = OPC_LUI;
      4'd6:        in.r.opcode = OPC_AUIPC;
      4'd7:        in.r.opcode = OPC_JAL;
      4'd8:        in.r.opcode = OPC_JALR;
      4'd9, 4'd10: in.r.opcode = OPC_BRANCH;
      4'd11, 4'd12: begin
        in.s.opcode = OPC_STORE;
        in.s.funct3 = in.s.funct3 & 3'b011; // size 011 stays in as an illegal store
      end
      4'd13:   in.r.opcode = known_opcode(w[6:0]) ? 7'b0000000 : w[6:0];
      4'd14:   in = w[0] ? INST_EBREAK : {w[31:7], OPC_SYSTEM};
      default: ;
    endcase
    i_valid     = (kind != 4'd15);
    i_inst      = in;
    i_pc        = $random(seed) & ~32'd3;
    i_rs1_rdata = $random(seed);
    i_rs2_rdata = (kind == 4'd10) ? i_rs1_rdata : $random(seed); // equal operands for branches
    e = '0;
    if (i_valid) e = predict(in, i_pc, i_rs1_rdata, i_rs2_rdata);
    exp_q.push_back(e);
  endtask

  task automatic check_outputs();
    exp_t e;
    e = exp_q.pop_front();
    check_bit("o_valid", o_valid, e.valid);
    check_bit("o_dmem_wen", o_dmem_wen, e.wen);
    check_bit("o_trap", o_trap, e.trap);
    check_bit("o_halt", o_halt, e.halt);
    if (e.valid) begin
      check_addr5("o_rd_waddr", o_rd_waddr, e.rd);
      check_word("o_next_pc", o_next_pc, e.next_pc);
    end
    if (e.chk_wd) check_word("o_rd_wdata", o_rd_wdata, e.rd_wdata);
    if (e.chk_st) begin
      check_word("o_dmem_addr", o_dmem_addr, e.addr);
      check_mask("o_dmem_mask", o_dmem_mask, e.mask);
      check_word("o_dmem_wdata", o_dmem_wdata, e.st_wdata);
    end
  endtask

  // reset is sampled on the rising edge and the outputs on the falling one
  task automatic wait_reset_release(output logic ok);
    int   cycles;
    logic in_reset;
    cycles   = 0;
    in_reset = 1'b1;
    while (in_reset && cycles < RST_TIMEOUT) begin
      @(posedge i_clk);
      in_reset = i_rst;
      @(negedge i_clk);
      check_bit("o_valid", o_valid, 1'b0);
      check_bit("o_dmem_wen", o_dmem_wen, 1'b0);
      cycles++;
    end
    ok = !in_reset;
    if (!ok) begin
      other_errs++;
      $display("reset was still asserted after %0d clock cycles", RST_TIMEOUT);
    end
  endtask

  initial begin
    seed       = 32'hff178d57;
    word_errs  = 0;
    rd_errs    = 0;
    mask_errs  = 0;
    flag_errs  = 0;
    other_errs = 0;
    wait_reset_release(rst_ok);
    if (rst_ok) begin
      repeat (NUM_INST) begin
        drive_random();
        @(negedge i_clk); // the registered result is stable here
        check_outputs();
      end
      i_valid = 1'b0;
    end
    $display("errors: word %0d, rd %0d, mask %0d, flag %0d, other %0d",
             word_errs, rd_errs, mask_errs, flag_errs, other_errs);
    if (word_errs + rd_errs + mask_errs + flag_errs + other_errs == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/ex_stage_assert.sv ====
`default_nettype none

module ex_stage_assert import ex_ctrl_pkg::*; (
  input logic              i_clk,
  input logic              i_rst,
  input logic              i_valid, // o_valid of the stage
  input logic              i_wen,
  input logic              i_trap,
  input logic [MASK_W-1:0] i_mask
);

  // a memory write only ever comes from a valid instruction that did not trap
  assert property (@(posedge i_clk) disable iff (i_rst) i_wen |-> (i_valid && !i_trap))
    else $error("store enable raised without a valid, trap-free result");

  // writing with no byte lane selected would be a silent no-op
  assert property (@(posedge i_clk) disable iff (i_rst) i_wen |-> (i_mask != '0))
    else $error("store enable raised with an empty byte mask");

  assert property (@(posedge i_clk) i_rst |=> !i_valid)
    else $error("valid output high in the cycle after reset");

endmodule

bind ex_stage ex_stage_assert u_assert (
  .i_clk(i_clk), .i_rst(i_rst), .i_valid(o_valid),
  .i_wen(o_dmem_wen), .i_trap(o_trap), .i_mask(o_dmem_mask)
);

`default_nettype wire

// ==== src/ex_stage.sv ====
`default_nettype none

module ex_stage import rv_isa_pkg::*, ex_ctrl_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_valid,
  input  logic [31:0]       i_inst,
  input  logic [XLEN-1:0]   i_pc,
  input  logic [XLEN-1:0]   i_rs1_rdata,
  input  logic [XLEN-1:0]   i_rs2_rdata,
  output logic              o_valid,
  output logic [4:0]        o_rd_waddr,
  output logic [XLEN-1:0]   o_rd_wdata,
  output logic [XLEN-1:0]   o_next_pc,
  output logic [XLEN-1:0]   o_dmem_addr,
  output logic [MASK_W-1:0] o_dmem_mask,
  output logic [XLEN-1:0]   o_dmem_wdata,
  output logic              o_dmem_wen,
  output logic              o_trap,
  output logic              o_halt
);

  // decoder outputs shared by the ALU and the store aligner
  logic [XLEN-1:0]     op_a, op_b, imm;
  logic [ALU_OP_W-1:0] alu_op;
  logic                is_branch, is_jal, is_jalr, is_store;
  logic                reg_write, wb_sel, illegal, halt;
  logic [2:0]          funct3;
  logic [4:0]          rd;

  logic [XLEN-1:0]     alu_result, target;
  logic                taken;
  logic [XLEN-1:0]     st_addr, st_wdata;
  logic [MASK_W-1:0]   st_mask;
  logic                st_misaligned;

  ex_decode u_decode (
    .i_inst(i_inst), .i_pc(i_pc), .i_rs1_rdata(i_rs1_rdata), .i_rs2_rdata(i_rs2_rdata),
    .o_op_a(op_a), .o_op_b(op_b), .o_imm(imm), .o_alu_op(alu_op),
    .o_is_branch(is_branch), .o_is_jal(is_jal), .o_is_jalr(is_jalr), .o_is_store(is_store),
    .o_reg_write(reg_write), .o_wb_sel(wb_sel), .o_illegal(illegal), .o_halt(halt),
    .o_funct3(funct3), .o_rd(rd)
  );

  ex_alu u_alu (
    .i_op_a(op_a), .i_op_b(op_b), .i_alu_op(alu_op),
    .i_rs1_rdata(i_rs1_rdata), .i_rs2_rdata(i_rs2_rdata), .i_pc(i_pc), .i_imm(imm),
    .i_funct3(funct3), .i_is_branch(is_branch), .i_is_jal(is_jal), .i_is_jalr(is_jalr),
    .o_result(alu_result), .o_taken(taken), .o_target(target)
  );

  lsu_store u_store (
    .i_rs1_rdata(i_rs1_rdata), .i_rs2_rdata(i_rs2_rdata), .i_imm(imm), .i_funct3(funct3),
    .o_addr(st_addr), .o_mask(st_mask), .o_wdata(st_wdata), .o_misaligned(st_misaligned)
  );

  ex_result_reg u_result (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid),
    .i_alu_result(alu_result), .i_taken(taken), .i_target(target),
    .i_pc(i_pc), .i_rd(rd), .i_reg_write(reg_write), .i_wb_sel(wb_sel),
    .i_is_store(is_store), .i_illegal(illegal), .i_halt(halt),
    .i_st_addr(st_addr), .i_st_mask(st_mask), .i_st_wdata(st_wdata),
    .i_st_misaligned(st_misaligned),
    .o_valid(o_valid), .o_rd_waddr(o_rd_waddr), .o_rd_wdata(o_rd_wdata),
    .o_next_pc(o_next_pc), .o_dmem_addr(o_dmem_addr), .o_dmem_mask(o_dmem_mask),
    .o_dmem_wdata(o_dmem_wdata), .o_dmem_wen(o_dmem_wen), .o_trap(o_trap), .o_halt(o_halt)
  );

endmodule

`default_nettype wire

// ==== src/ex_result_reg.sv ====
`default_nettype none

module ex_result_reg import rv_isa_pkg::*, ex_ctrl_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_valid,
  input  logic [XLEN-1:0]   i_alu_result,
  input  logic              i_taken,
  input  logic [XLEN-1:0]   i_target,
  input  logic [XLEN-1:0]   i_pc,
  input  logic [4:0]        i_rd,
  input  logic              i_reg_write,
  input  logic              i_wb_sel,
  input  logic              i_is_store,
  input  logic              i_illegal,
  input  logic              i_halt,
  input  logic [XLEN-1:0]   i_st_addr,
  input  logic [MASK_W-1:0] i_st_mask,
  input  logic [XLEN-1:0]   i_st_wdata,
  input  logic              i_st_misaligned,
  output logic              o_valid,
  output logic [4:0]        o_rd_waddr,
  output logic [XLEN-1:0]   o_rd_wdata,
  output logic [XLEN-1:0]   o_next_pc,
  output logic [XLEN-1:0]   o_dmem_addr,
  output logic [MASK_W-1:0] o_dmem_mask,
  output logic [XLEN-1:0]   o_dmem_wdata,
  output logic              o_dmem_wen,
  output logic              o_trap,
  output logic              o_halt
);

  logic [XLEN-1:0] pc_plus4;
  logic            trap;

  assign pc_plus4 = i_pc + 32'd4;

  // a taken target must land on a word, the store must fit its size
  assign trap = i_illegal | (i_is_store & i_st_misaligned) | (i_taken & |i_target[1:0]);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid      <= 1'b0;
      o_dmem_wen   <= 1'b0;
      o_trap       <= 1'b0;
      o_halt       <= 1'b0;
      o_rd_waddr   <= '0;
      o_rd_wdata   <= '0;
      o_next_pc    <= '0;
      o_dmem_addr  <= '0;
      o_dmem_mask  <= '0;
      o_dmem_wdata <= '0;
    end else begin
      o_valid    <= i_valid;                         // one pulse per accepted instruction
      o_dmem_wen <= i_valid & i_is_store & ~trap;    // a trapping store never reaches memory
      o_trap     <= i_valid & trap;
      o_halt     <= i_valid & i_halt;
      if (i_valid) begin
        o_rd_waddr   <= (i_reg_write & ~trap) ? i_rd : 5'd0; // rd 0 means no write
        o_rd_wdata   <= (i_wb_sel == WB_LINK) ? pc_plus4 : i_alu_result;
        o_next_pc    <= i_taken ? i_target : pc_plus4; // reported even when trapping
        o_dmem_addr  <= i_st_addr;
        o_dmem_mask  <= i_st_mask;
        o_dmem_wdata <= i_st_wdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== lsu/lsu_store.sv ====
`default_nettype none

module lsu_store import rv_isa_pkg::*, ex_ctrl_pkg::*; (
  input  logic [XLEN-1:0]   i_rs1_rdata,
  input  logic [XLEN-1:0]   i_rs2_rdata,
  input  logic [XLEN-1:0]   i_imm,
  input  logic [2:0]        i_funct3,
  output logic [XLEN-1:0]   o_addr,
  output logic [MASK_W-1:0] o_mask,
  output logic [XLEN-1:0]   o_wdata,
  output logic              o_misaligned
);

  logic [XLEN-1:0] eff_addr; // byte address the store points at
  logic [1:0]      offset;   // byte lane within the aligned word

  assign eff_addr = i_rs1_rdata + i_imm;
  assign offset   = eff_addr[1:0];
  assign o_addr   = {eff_addr[XLEN-1:2], 2'b00}; // memory only sees word addresses

  always_comb begin
    o_mask       = '0;
    o_wdata      = i_rs2_rdata;
    o_misaligned = 1'b0;
    case (i_funct3)
      F3_SB: begin
        o_mask  = 4'b0001 << offset;
        o_wdata = {4{i_rs2_rdata[7:0]}} & ({{24{1'b0}}, 8'hff} << {offset, 3'b000});
      end
      F3_SH: begin
        o_mask       = offset[1] ? 4'b1100 : 4'b0011; // upper or lower half of the word
        o_wdata      = offset[1] ? {i_rs2_rdata[15:0], 16'h0000} : {16'h0000, i_rs2_rdata[15:0]};
        o_misaligned = offset[0];
      end
      F3_SW: begin
        o_mask       = 4'b1111;
        o_misaligned = |offset;
      end
      default: o_mask = '0; // not a store size, the decoder flags it as illegal
    endcase
  end

endmodule

`default_nettype wire

// ==== alu/ex_alu.sv ====
`default_nettype none

module ex_alu import rv_isa_pkg::*, ex_ctrl_pkg::*; (
  input  logic [XLEN-1:0]     i_op_a,
  input  logic [XLEN-1:0]     i_op_b,
  input  logic [ALU_OP_W-1:0] i_alu_op,
  input  logic [XLEN-1:0]     i_rs1_rdata,
  input  logic [XLEN-1:0]     i_rs2_rdata,
  input  logic [XLEN-1:0]     i_pc,
  input  logic [XLEN-1:0]     i_imm,
  input  logic [2:0]          i_funct3,
  input  logic                i_is_branch,
  input  logic                i_is_jal,
  input  logic                i_is_jalr,
  output logic [XLEN-1:0]     o_result,
  output logic                o_taken,
  output logic [XLEN-1:0]     o_target
);

  logic [4:0]      shamt;     // shifts only look at the low five bits
  logic            cond;      // branch condition holds
  logic [XLEN-1:0] jalr_sum;  // rs1 + imm before bit 0 is dropped

  assign shamt = i_op_b[4:0];

  always_comb begin
    case (i_alu_op)
      ALU_SUB:  o_result = i_op_a - i_op_b;
      ALU_SLL:  o_result = i_op_a << shamt;
      ALU_SLT:  o_result = {31'd0, $signed(i_op_a) < $signed(i_op_b)};
      ALU_SLTU: o_result = {31'd0, i_op_a < i_op_b};
      ALU_XOR:  o_result = i_op_a ^ i_op_b;
      ALU_SRL:  o_result = i_op_a >> shamt;
      ALU_SRA:  o_result = $unsigned($signed(i_op_a) >>> shamt);
      ALU_OR:   o_result = i_op_a | i_op_b;
      ALU_AND:  o_result = i_op_a & i_op_b;
      default:  o_result = i_op_a + i_op_b; // ALU_ADD, also lui and auipc
    endcase
  end

  // branches compare the raw register values and never the operand muxes
  always_comb begin
    case (i_funct3)
      F3_BEQ:  cond = (i_rs1_rdata == i_rs2_rdata);
      F3_BNE:  cond = (i_rs1_rdata != i_rs2_rdata);
      F3_BLT:  cond = ($signed(i_rs1_rdata) < $signed(i_rs2_rdata));
      F3_BGE:  cond = ($signed(i_rs1_rdata) >= $signed(i_rs2_rdata));
      F3_BLTU: cond = (i_rs1_rdata < i_rs2_rdata);
      F3_BGEU: cond = (i_rs1_rdata >= i_rs2_rdata);
      default: cond = 1'b0; // reserved codes are trapped by the decoder anyway
    endcase
  end

  assign jalr_sum = i_rs1_rdata + i_imm;

  // jalr clears bit 0 only, bit 1 is left for the misalignment trap to see
  assign o_target = i_is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : i_pc + i_imm;
  assign o_taken  = i_is_jal | i_is_jalr | (i_is_branch & cond);

endmodule

`default_nettype wire

// ==== src/ex_decode.sv ====
`default_nettype none

module ex_decode import rv_isa_pkg::*, ex_ctrl_pkg::*; (
  input  inst_u                i_inst,
  input  logic [XLEN-1:0]      i_pc,
  input  logic [XLEN-1:0]      i_rs1_rdata,
  input  logic [XLEN-1:0]      i_rs2_rdata,
  output logic [XLEN-1:0]      o_op_a,
  output logic [XLEN-1:0]      o_op_b,
  output logic [XLEN-1:0]      o_imm,
  output logic [ALU_OP_W-1:0]  o_alu_op,
  output logic                 o_is_branch,
  output logic                 o_is_jal,
  output logic                 o_is_jalr,
  output logic                 o_is_store,
  output logic                 o_reg_write,
  output logic                 o_wb_sel,
  output logic                 o_illegal,
  output logic                 o_halt,
  output logic [2:0]           o_funct3,
  output logic [4:0]           o_rd
);

  // alt is funct7 bit 5, which turns add into sub and srl into sra
  function automatic logic [ALU_OP_W-1:0] alu_code(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD_SUB: alu_code = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_code = ALU_SLL;
      F3_SLT:     alu_code = ALU_SLT;
      F3_SLTU:    alu_code = ALU_SLTU;
      F3_XOR:     alu_code = ALU_XOR;
      F3_SRL_SRA: alu_code = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_code = ALU_OR;
      default:    alu_code = ALU_AND;
    endcase
  endfunction

  assign o_funct3 = i_inst.r.funct3;
  assign o_rd     = i_inst.r.rd;

  always_comb begin
    o_imm       = '0;
    o_op_a      = i_rs1_rdata; // most instructions work on rs1
    o_alu_op    = ALU_ADD;
    o_is_branch = 1'b0;
    o_is_jal    = 1'b0;
    o_is_jalr   = 1'b0;
    o_is_store  = 1'b0;
    o_reg_write = 1'b0;
    o_wb_sel    = WB_ALU;
    o_illegal   = 1'b0;
    o_halt      = 1'b0;
    case (i_inst.r.opcode)
      OPC_OP: begin
        o_reg_write = 1'b1;
        o_alu_op    = alu_code(i_inst.r.funct3, i_inst.r.funct7[5]);
      end
      OPC_OP_IMM: begin
        o_imm       = {{20{i_inst.i.imm[11]}}, i_inst.i.imm};
        o_reg_write = 1'b1;
        // bit 30 only means something for the right shift, addi keeps a plain immediate
        o_alu_op    = alu_code(i_inst.i.funct3,
                               i_inst.r.funct7[5] && (i_inst.i.funct3 == F3_SRL_SRA));
      end
      OPC_LUI, OPC_AUIPC: begin
        // U immediate is the whole upper word of the I view
        o_imm       = {i_inst.i.imm, i_inst.i.rs1, i_inst.i.funct3, 12'h000};
        o_op_a      = (i_inst.r.opcode == OPC_LUI) ? '0 : i_pc;
        o_reg_write = 1'b1;
      end
      OPC_JAL: begin
        // J immediate, bits 19:12 are the rs1 and funct3 fields of the I view
        o_imm       = {{12{i_inst.i.imm[11]}}, i_inst.i.rs1, i_inst.i.funct3,
                       i_inst.i.imm[0], i_inst.i.imm[10:1], 1'b0};
        o_is_jal    = 1'b1;
        o_reg_write = 1'b1;
        o_wb_sel    = WB_LINK;
      end
      OPC_JALR: begin
        o_imm       = {{20{i_inst.i.imm[11]}}, i_inst.i.imm};
        o_is_jalr   = 1'b1;
        o_reg_write = 1'b1;
        o_wb_sel    = WB_LINK;
      end
      OPC_BRANCH: begin
        // B immediate is the S layout with bit 11 moved down into imm_lo[0]
        o_imm       = {{20{i_inst.s.imm_hi[6]}}, i_inst.s.imm_lo[0], i_inst.s.imm_hi[5:0],
                       i_inst.s.imm_lo[4:1], 1'b0};
        o_is_branch = 1'b1;
        o_illegal   = (i_inst.s.funct3 == 3'b010) || (i_inst.s.funct3 == 3'b011);
      end
      OPC_STORE: begin
        o_imm      = {{20{i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
        o_is_store = 1'b1;
        o_illegal  = (i_inst.s.funct3 > F3_SW); // only byte, half and word exist
      end
      OPC_SYSTEM: o_halt = (i_inst == INST_EBREAK); // other system words retire as no-ops
      default:    o_illegal = 1'b1;
    endcase
  end

  assign o_op_b = (i_inst.r.opcode == OPC_OP) ? i_rs2_rdata : o_imm; // register or immediate

endmodule

`default_nettype wire

// ==== common/ex_ctrl_pkg.sv ====
`default_nettype none

package ex_ctrl_pkg;

  localparam int ALU_OP_W = 4; // width of the operation code handed to the ALU

  // ALU operation codes, the encoding is internal to the stage
  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;

  // one enable bit per byte lane of a data word
  localparam int MASK_W = 4;

  // where the rd write data comes from
  localparam logic WB_ALU  = 1'b0; // ALU result
  localparam logic WB_LINK = 1'b1; // return address pc+4 of a jump

endpackage

`default_nettype wire

// ==== common/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  localparam int XLEN = 32; // data and address width of the hart

  // major opcodes the execute stage understands
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // branch conditions, funct3 of the branch opcode
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // store sizes, funct3 of the store opcode
  localparam logic [2:0] F3_SB = 3'b000;
  localparam logic [2:0] F3_SH = 3'b001;
  localparam logic [2:0] F3_SW = 3'b010;

  // integer operations, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101; // funct7 bit 5 picks the arithmetic shift
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [31:0] INST_EBREAK = 32'h00100073; // the only SYSTEM word that halts

  // one instruction word seen through the three encodings the decoder needs
  // B, J and U immediates are reassembled from these same fields
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi; // imm[11:5], also the branch offset high part
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo; // imm[4:0] sits where rd would be
      logic [6:0] opcode;
    } s;
  } inst_u;

endpackage

`default_nettype wire
